//--- src/rxdp_mode_pkg.sv
/*
 * RX datapath adapter mode definitions
 * Transfer-mode encodings, marker-bit select width and the
 * word alignment lock patterns for half and quarter rate
 */
package rxdp_mode_pkg;

   // ************************************************
   // Transfer modes
   // ************************************************
   typedef enum logic [1:0] {
      FIFO_1X = 2'b00,   // Full rate, one word per entry
      FIFO_2X = 2'b01,   // Half rate, two beats per entry
      FIFO_4X = 2'b10,   // Quarter rate, four beats per entry
      REG_MOD = 2'b11    // Register mode, same as full rate
   } fifo_mode_e;

   // ************************************************
   // Word alignment
   // ************************************************
   // Marker select covers word bits 79..76 and 39
   localparam int MK_WIDTH = 5;

   localparam int HIST_LEN = 12;  // Marker history depth

   // Newest marker in bit 0
   localparam logic [HIST_LEN-1:0] LOCK_PAT_4X = 12'h111;  // Every fourth beat
   localparam logic [5:0]          LOCK_PAT_2X = 6'h15;    // Every second beat

endpackage

//--- src/rxdp_fifo_pkg.sv
/*
 * RX datapath adapter FIFO geometry
 * Word and entry widths, depth and the shared entry count type
 */
package rxdp_fifo_pkg;

   // ************************************************
   // Widths
   // ************************************************
   localparam int DWIDTH = 80;          // Incoming word, one quarter of an entry
   localparam int HWIDTH = 40;          // Gen1 half-rate half word
   localparam int EWIDTH = 4 * DWIDTH;  // Packed entry, 320 bits

   // ************************************************
   // Depth
   // ************************************************
   localparam int AWIDTH = 4;
   localparam int DEPTH  = 1 << AWIDTH;  // 16 entries

   // Entry count, wraps past DEPTH-1
   typedef logic [AWIDTH-1:0] count_t;

endpackage

//--- src/rxdp_fifo_ram.sv
/*
 * RX adapter FIFO storage
 * Register array with one-hot write and read selects,
 * unregistered AND-OR read (first-word fall-through)
 */
`timescale 1ns/1ns

module rxdp_fifo_ram
   import rxdp_fifo_pkg::*;
(
   input  logic              wr_clk,
   input  logic              wr_en,     // Write strobe from packer
   input  logic [DEPTH-1:0]  wr_ptr,    // One-hot write select
   input  logic [EWIDTH-1:0] wr_data,
   input  logic [DEPTH-1:0]  rd_ptr,    // One-hot read select
   output logic [EWIDTH-1:0] rd_data
);

   logic [EWIDTH-1:0] mem [DEPTH];  // Payload only

   // ************************************************
   // Write port
   // ************************************************
   always_ff @(posedge wr_clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (wr_en && wr_ptr[i]) begin
            mem[i] <= wr_data;  // Select bit picks the entry
         end
      end
   end

   // ************************************************
   // Read port
   // ************************************************
   // AND-OR mux, one select bit high at a time
   always_comb begin
      rd_data = '0;
      for (int i = 0; i < DEPTH; i++) begin
         rd_data = rd_data | ({EWIDTH{rd_ptr[i]}} & mem[i]);
      end
   end

endmodule

//--- src/rxdp_fifo_ptr.sv
/*
 * RX adapter FIFO pointers
 * Binary and Gray pointers per domain, two-flop Gray crossing,
 * one-hot decode for the RAM and the entry count in each domain
 */
`timescale 1ns/1ns

module rxdp_fifo_ptr
   import rxdp_fifo_pkg::*;
(
   input  logic             wr_clk,
   input  logic             wr_rst_n,
   input  logic             rd_clk,
   input  logic             rd_rst_n,
   input  logic             wr_en,           // Entry write strobe
   input  logic             rd_en,           // Entry read strobe
   output logic [DEPTH-1:0] wr_ptr_one_hot,
   output logic [DEPTH-1:0] rd_ptr_one_hot,
   output count_t           wr_count,        // Entries seen by write side
   output count_t           rd_count         // Entries seen by read side
);

   logic [AWIDTH-1:0] wr_bin, wr_gray, wr_bin_next;
   logic [AWIDTH-1:0] rd_bin, rd_gray, rd_bin_next;
   logic [AWIDTH-1:0] rd_gray_w1, rd_gray_w2;  // Read ptr in write domain
   logic [AWIDTH-1:0] wr_gray_r1, wr_gray_r2;  // Write ptr in read domain

   function automatic logic [AWIDTH-1:0] bin2gray(input logic [AWIDTH-1:0] b);
      return b ^ (b >> 1);
   endfunction

   function automatic logic [AWIDTH-1:0] gray2bin(input logic [AWIDTH-1:0] g);
      logic [AWIDTH-1:0] b;
      b[AWIDTH-1] = g[AWIDTH-1];
      for (int i = AWIDTH - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];  // Running XOR from the top
      end
      return b;
   endfunction

   assign wr_bin_next = wr_bin + AWIDTH'(1);
   assign rd_bin_next = rd_bin + AWIDTH'(1);

   // ************************************************
   // Write domain
   // ************************************************
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_bin     <= '0;
         wr_gray    <= '0;
         rd_gray_w1 <= '0;
         rd_gray_w2 <= '0;
      end else begin
         if (wr_en) begin
            wr_bin  <= wr_bin_next;
            wr_gray <= bin2gray(wr_bin_next);  // Kept in step with binary
         end
         rd_gray_w1 <= rd_gray;     // Crossing stage 1
         rd_gray_w2 <= rd_gray_w1;  // Crossing stage 2
      end
   end

   assign wr_count       = wr_bin - gray2bin(rd_gray_w2);  // Modulo DEPTH
   assign wr_ptr_one_hot = DEPTH'(1) << wr_bin;

   // ************************************************
   // Read domain
   // ************************************************
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_bin     <= '0;
         rd_gray    <= '0;
         wr_gray_r1 <= '0;
         wr_gray_r2 <= '0;
      end else begin
         if (rd_en) begin
            rd_bin  <= rd_bin_next;
            rd_gray <= bin2gray(rd_bin_next);
         end
         wr_gray_r1 <= wr_gray;
         wr_gray_r2 <= wr_gray_r1;
      end
   end

   // Read select moves with rd_bin, so rd_data follows in the same cycle
   assign rd_count       = gray2bin(wr_gray_r2) - rd_bin;
   assign rd_ptr_one_hot = DEPTH'(1) << rd_bin;

endmodule

//--- src/rxdp_fifo_flags.sv
/*
 * RX adapter FIFO fill flags
 * Registered threshold compare of an entry count, one instance per domain
 */
`timescale 1ns/1ns

module rxdp_fifo_flags
   import rxdp_fifo_pkg::*;
(
   input  logic   clk,       // Local domain clock
   input  logic   rst_n,     // Local domain reset, synchronous
   input  count_t count,     // Local entry count
   input  count_t r_empty,
   input  count_t r_pempty,
   input  count_t r_full,
   input  count_t r_pfull,
   output logic   empty,
   output logic   pempty,
   output logic   full,
   output logic   pfull
);

   // ************************************************
   // Threshold compare
   // ************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         // Empty after reset
         empty  <= 1'b1;
         pempty <= 1'b1;
         full   <= 1'b0;
         pfull  <= 1'b0;
      end else begin
         empty  <= (count <= r_empty);   // At or below empty mark
         pempty <= (count <= r_pempty);
         full   <= (count >= r_full);    // At or above full mark
         pfull  <= (count >= r_pfull);
      end
   end

endmodule

//--- src/rxdp_word_packer.sv
/*
 * RX adapter word packer
 * Beat counter and entry assembly for full, half and quarter rate,
 * with the FIFO write strobe one cycle after the last beat
 */
`timescale 1ns/1ns

module rxdp_word_packer
   import rxdp_mode_pkg::*;
   import rxdp_fifo_pkg::*;
(
   input  logic              wr_clk,
   input  logic              wr_rst_n,
   input  logic              wr_en,         // Beat valid
   input  logic [DWIDTH-1:0] wr_data,
   input  fifo_mode_e        r_fifo_mode,
   input  logic              r_wa_en,       // Word alignment enable
   input  logic              m_gen2_mode,   // Gen2 when high, else Gen1
   output logic              fifo_wr_en,    // Entry write strobe
   output logic [EWIDTH-1:0] fifo_wr_data   // Packed entry
);

   logic [1:0]        wr_cnt;               // Beat position in group
   logic [DWIDTH-1:0] wd0, wd1, wd2, wd3;   // Entry words, no reset
   logic              last_beat;

   // Last beat of each group
   always_comb begin
      case (r_fifo_mode)
         FIFO_4X: last_beat = (wr_cnt == 2'd3);
         FIFO_2X: last_beat = wr_cnt[0];
         default: last_beat = 1'b1;        // 1x and register mode
      endcase
   end

   // ************************************************
   // Beat counter and write strobe
   // ************************************************
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_cnt     <= 2'd0;
         fifo_wr_en <= 1'b0;
      end else begin
         if (r_wa_en && wr_en) begin
            wr_cnt <= wr_cnt + 2'd1;        // Counts only with alignment on
         end
         fifo_wr_en <= wr_en && last_beat;
      end
   end

   // ************************************************
   // Entry assembly
   // ************************************************
   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         case (r_fifo_mode)
            FIFO_4X: begin
               case (wr_cnt)
                  2'd0: wd0 <= wr_data;
                  2'd1: wd1 <= wr_data;
                  2'd2: wd2 <= wr_data;
                  default: wd3 <= wr_data;
               endcase
            end
            FIFO_2X: begin
               if (m_gen2_mode) begin
                  if (wr_cnt[0]) wd1 <= wr_data;  // Second beat
                  else wd0 <= wr_data;
               end else if (wr_cnt[0]) begin
                  wd0[DWIDTH-1:HWIDTH] <= wr_data[HWIDTH-1:0];  // Gen1 high half
               end else begin
                  wd0[HWIDTH-1:0] <= wr_data[HWIDTH-1:0];
               end
            end
            default: begin
               wd0 <= wr_data;
               wd1 <= '0;
               wd2 <= '0;
               wd3 <= '0;
            end
         endcase
      end
   end

   assign fifo_wr_data = {wd3, wd2, wd1, wd0};  // Word 0 in the low bits

endmodule

//--- src/rxdp_marker_lock.sv
/*
 * RX adapter word alignment lock
 * Marker bit extraction, marker history and sticky lock flag
 */
`timescale 1ns/1ns

module rxdp_marker_lock
   import rxdp_mode_pkg::*;
   import rxdp_fifo_pkg::*;
(
   input  logic                wr_clk,
   input  logic                wr_rst_n,
   input  logic [DWIDTH-1:0]   wr_data,
   input  logic [MK_WIDTH-1:0] r_mkbit,      // Marker select, bits 79..76 and 39
   input  fifo_mode_e          r_fifo_mode,
   input  logic                r_wa_en,
   output logic                wa_lock       // Sticky until reset
);

   logic                mk_bit;
   logic [HIST_LEN-1:0] mk_hist;        // Oldest marker in the top bit
   logic [HIST_LEN-1:0] mk_hist_next;
   logic                lock_hit;

   assign mk_bit       = |({wr_data[79:76], wr_data[39]} & r_mkbit);
   assign mk_hist_next = {mk_hist[HIST_LEN-2:0], mk_bit};

   // Pattern compare on the history including this beat
   always_comb begin
      case (r_fifo_mode)
         FIFO_4X: lock_hit = (mk_hist_next == LOCK_PAT_4X);
         FIFO_2X: lock_hit = (mk_hist_next[5:0] == LOCK_PAT_2X);
         default: lock_hit = 1'b1;   // No marker needed
      endcase
   end

   // ************************************************
   // History and lock
   // ************************************************
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         mk_hist <= '0;
         wa_lock <= 1'b0;
      end else if (r_wa_en) begin
         mk_hist <= mk_hist_next;          // Shifts every cycle
         wa_lock <= wa_lock | lock_hit;
      end
   end

endmodule

//--- src/rxdp_async_fifo.sv
/*
 * RX datapath adapter asynchronous FIFO
 * Packs 80-bit words into 320-bit entries on wr_clk, drains them on rd_clk,
 * with fill flags in both domains and a word alignment lock flag
 */
`timescale 1ns/1ns

module rxdp_async_fifo
   import rxdp_mode_pkg::*;
   import rxdp_fifo_pkg::*;
(
   input  logic                wr_clk,
   input  logic                wr_rst_n,
   input  logic                wr_en,
   input  logic [DWIDTH-1:0]   wr_data,
   input  logic                rd_clk,
   input  logic                rd_rst_n,
   input  logic                rd_en,
   input  count_t              r_pempty,     // Thresholds, shared by both domains
   input  count_t              r_pfull,
   input  count_t              r_empty,
   input  count_t              r_full,       // At most DEPTH-1
   input  fifo_mode_e          r_fifo_mode,
   input  logic                r_wa_en,
   input  logic                m_gen2_mode,
   input  logic [MK_WIDTH-1:0] r_mkbit,
   output logic [EWIDTH-1:0]   rd_data,
   output logic                wa_lock,
   output logic                wr_empty,
   output logic                wr_pempty,
   output logic                wr_full,
   output logic                wr_pfull,
   output logic                rd_empty,
   output logic                rd_pempty,
   output logic                rd_full,
   output logic                rd_pfull
);

   logic              fifo_wr_en;
   logic [EWIDTH-1:0] fifo_wr_data;
   logic [DEPTH-1:0]  wr_ptr_one_hot;
   logic [DEPTH-1:0]  rd_ptr_one_hot;
   count_t            wr_count;
   count_t            rd_count;

   // ************************************************
   // Write side front end
   // ************************************************
   rxdp_word_packer u_packer (
      .wr_clk       (wr_clk),
      .wr_rst_n     (wr_rst_n),
      .wr_en        (wr_en),
      .wr_data      (wr_data),
      .r_fifo_mode  (r_fifo_mode),
      .r_wa_en      (r_wa_en),
      .m_gen2_mode  (m_gen2_mode),
      .fifo_wr_en   (fifo_wr_en),
      .fifo_wr_data (fifo_wr_data)
   );

   rxdp_marker_lock u_lock (
      .wr_clk      (wr_clk),
      .wr_rst_n    (wr_rst_n),
      .wr_data     (wr_data),
      .r_mkbit     (r_mkbit),
      .r_fifo_mode (r_fifo_mode),
      .r_wa_en     (r_wa_en),
      .wa_lock     (wa_lock)
   );

   // ************************************************
   // FIFO core
   // ************************************************
   rxdp_fifo_ptr u_ptr (
      .wr_clk         (wr_clk),
      .wr_rst_n       (wr_rst_n),
      .rd_clk         (rd_clk),
      .rd_rst_n       (rd_rst_n),
      .wr_en          (fifo_wr_en),     // Packed entries only
      .rd_en          (rd_en),
      .wr_ptr_one_hot (wr_ptr_one_hot),
      .rd_ptr_one_hot (rd_ptr_one_hot),
      .wr_count       (wr_count),
      .rd_count       (rd_count)
   );

   rxdp_fifo_ram u_ram (
      .wr_clk  (wr_clk),
      .wr_en   (fifo_wr_en),
      .wr_ptr  (wr_ptr_one_hot),
      .wr_data (fifo_wr_data),
      .rd_ptr  (rd_ptr_one_hot),
      .rd_data (rd_data)
   );

   // ************************************************
   // Fill flags, one set per domain
   // ************************************************
   rxdp_fifo_flags u_wr_flags (
      .clk      (wr_clk),
      .rst_n    (wr_rst_n),
      .count    (wr_count),
      .r_empty  (r_empty),
      .r_pempty (r_pempty),
      .r_full   (r_full),
      .r_pfull  (r_pfull),
      .empty    (wr_empty),
      .pempty   (wr_pempty),
      .full     (wr_full),
      .pfull    (wr_pfull)
   );

   rxdp_fifo_flags u_rd_flags (
      .clk      (rd_clk),
      .rst_n    (rd_rst_n),
      .count    (rd_count),
      .r_empty  (r_empty),
      .r_pempty (r_pempty),
      .r_full   (r_full),
      .r_pfull  (r_pfull),
      .empty    (rd_empty),
      .pempty   (rd_pempty),
      .full     (rd_full),
      .pfull    (rd_pfull)
   );

endmodule

//--- tb/rxdp_async_fifo_sva.sv
/*
 * Assertions for the RX adapter FIFO
 * Overrun, underrun, 4x strobe spacing and sticky lock
 */
`timescale 1ns/1ns

module rxdp_async_fifo_sva
   import rxdp_mode_pkg::*;
(
   input logic       wr_clk,
   input logic       wr_rst_n,
   input logic       rd_clk,
   input logic       rd_rst_n,
   input logic       fifo_wr_en,   // Packed entry write
   input logic       wr_full,
   input logic       rd_en,
   input logic       rd_empty,
   input fifo_mode_e r_fifo_mode,
   input logic       wa_lock
);

   // **************************************************
   // FIFO usage
   // **************************************************
   no_write_when_full : assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      !(fifo_wr_en && wr_full)) else $error("Entry written while wr_full is high");

   no_read_when_empty : assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      !(rd_en && rd_empty)) else $error("Entry read while rd_empty is high");

   // One entry per four beats
   single_strobe_4x : assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      (fifo_wr_en && r_fifo_mode == FIFO_4X) |=> !fifo_wr_en)
      else $error("Back-to-back entry writes in 4x mode");

   // **************************************************
   // Lock
   // **************************************************
   lock_sticky : assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      wa_lock |=> wa_lock) else $error("wa_lock fell outside reset");

endmodule

//--- tb/rxdp_async_fifo_tb.sv
/*
 * Testbench for the RX datapath adapter FIFO
 * LFSR stimulus in all transfer modes against a queue model,
 * fill flag and word alignment lock checks
 */
`timescale 1ns/1ns

module rxdp_async_fifo_tb
   import rxdp_mode_pkg::*;
   import rxdp_fifo_pkg::*;
();

   localparam int N_1X = 200;  // Beats per traffic test
   localparam int N_4X = 96;
   localparam int N_2X = 80;
   localparam int MAX_CYCLES = (N_1X + N_4X + 2 * N_2X + 32) * 12 + 2000;

   logic wr_clk = 1'b0;
   logic rd_clk = 1'b0;
   logic wr_rst_n, rd_rst_n, wr_en, rd_en, r_wa_en, m_gen2_mode, wa_lock;
   logic [DWIDTH-1:0]   wr_data;
   logic [EWIDTH-1:0]   rd_data;
   logic [MK_WIDTH-1:0] r_mkbit;
   count_t              r_pempty, r_pfull, r_empty, r_full;
   fifo_mode_e          r_fifo_mode;
   logic wr_empty, wr_pempty, wr_full, wr_pfull;
   logic rd_empty, rd_pempty, rd_full, rd_pfull;

   // Reference model, one expected entry and compare mask per FIFO entry
   logic [EWIDTH-1:0] exp_q[$];
   logic [EWIDTH-1:0] mask_q[$];
   logic [EWIDTH-1:0] pack_buf = '0;
   int                beat_idx = 0;       // Position in the current group
   logic [31:0]       lfsr_state = 32'd54;
   int  error_count = 0;
   int  check_count = 0;
   int  cycle_count = 0;
   int  empty_wait = 0;
   bit  reader_on = 1'b0;
   int  flag_points[6] = '{0, 1, 3, 5, 9, 12};  // Entry counts for the flag test

   always #5 wr_clk = ~wr_clk;
   always #7 rd_clk = ~rd_clk;

   rxdp_async_fifo i_rxdp_async_fifo (.*);

   bind rxdp_async_fifo rxdp_async_fifo_sva u_sva (
      .wr_clk      (wr_clk),
      .wr_rst_n    (wr_rst_n),
      .rd_clk      (rd_clk),
      .rd_rst_n    (rd_rst_n),
      .fifo_wr_en  (fifo_wr_en),
      .wr_full     (wr_full),
      .rd_en       (rd_en),
      .rd_empty    (rd_empty),
      .r_fifo_mode (r_fifo_mode),
      .wa_lock     (wa_lock)
   );

   // **************************************************
   // Helpers
   // **************************************************
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois, right shift
   endfunction

   task automatic take_bits(input int n, output logic [DWIDTH-1:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);  // One step per bit
         v[i] = lfsr_state[0];
      end
   endtask

   task automatic check_value(input string name, input logic [EWIDTH-1:0] expected,
                              input logic [EWIDTH-1:0] actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("MISMATCH at %0t: %s expected %0h, got %0h",
                  $time, name, expected, actual);
      end
   endtask

   // Expected {empty, pempty, full, pfull} for n stored entries
   function automatic logic [3:0] flag_rules(input int n);
      return {n <= int'(r_empty), n <= int'(r_pempty),
              n >= int'(r_full), n >= int'(r_pfull)};
   endfunction

   task automatic drive_beat(input logic en, input logic [DWIDTH-1:0] data);
      @(posedge wr_clk);
      #1;
      wr_en   = en;
      wr_data = data;
   endtask

   // Packing rules per mode, pushes one entry per completed group
   task automatic model_beat(input logic [DWIDTH-1:0] d);
      int                last;
      logic [EWIDTH-1:0] mask;
      if (r_fifo_mode == FIFO_4X) begin
         last = 3;
         mask = '1;
         pack_buf[beat_idx*DWIDTH +: DWIDTH] = d;
      end else if (r_fifo_mode == FIFO_2X && m_gen2_mode) begin
         last = 1;
         mask = EWIDTH'({2*DWIDTH{1'b1}});  // Words 0 and 1
         pack_buf[beat_idx*DWIDTH +: DWIDTH] = d;
      end else if (r_fifo_mode == FIFO_2X) begin
         last = 1;
         mask = EWIDTH'({DWIDTH{1'b1}});    // Word 0 only
         pack_buf[beat_idx*HWIDTH +: HWIDTH] = d[HWIDTH-1:0];
      end else begin
         last = 0;
         mask = '1;
         pack_buf = EWIDTH'(d);  // Words 1 to 3 zero
      end
      if (beat_idx == last) begin
         exp_q.push_back(pack_buf);
         mask_q.push_back(mask);
         pack_buf = '0;
         beat_idx = 0;
      end else begin
         beat_idx++;
      end
   endtask

   task automatic apply_reset(input fifo_mode_e mode, input logic gen2);
      @(posedge wr_clk);
      #1;
      wr_rst_n    = 1'b0;
      reader_on   = 1'b0;
      wr_en       = 1'b0;
      wr_data     = '0;
      r_fifo_mode = mode;
      m_gen2_mode = gen2;
      r_empty     = count_t'(0);
      r_pempty    = count_t'(3);
      r_pfull     = count_t'(8);   // Writer backs off here
      r_full      = count_t'(15);
      exp_q.delete();
      mask_q.delete();
      pack_buf = '0;
      beat_idx = 0;
      @(posedge rd_clk);
      #1;
      rd_rst_n = 1'b0;
      repeat (3) @(posedge wr_clk);
      #1;
      wr_rst_n = 1'b1;
      repeat (2) @(posedge rd_clk);
      #1;
      rd_rst_n = 1'b1;
   endtask

   // **************************************************
   // Traffic and flag tests
   // **************************************************
   task automatic run_traffic(input string name, input fifo_mode_e mode, input logic gen2,
                              input int n_beats, input logic with_lock);
      logic [DWIDTH-1:0] d;
      logic [DWIDTH-1:0] gap;
      int                errors_before;
      errors_before = error_count;
      apply_reset(mode, gen2);
      reader_on = 1'b1;
      for (int i = 0; i < n_beats; i++) begin
         take_bits(DWIDTH, d);
         if (with_lock && i < 12) begin
            d[39] = (i % 4 == 3);  // Marker on the last beat of a group, no gaps
         end else begin
            take_bits(2, gap);
            repeat (int'(gap[1:0])) drive_beat(1'b0, '0);
            while (wr_pfull) drive_beat(1'b0, '0);
         end
         drive_beat(1'b1, d);
         model_beat(d);
         if (with_lock && i == 11) begin
            check_value("wa_lock", '0, EWIDTH'(wa_lock));       // Eleven beats seen
            drive_beat(1'b0, '0);
            check_value("wa_lock", EWIDTH'(1'b1), EWIDTH'(wa_lock));
         end
      end
      drive_beat(1'b0, '0);
      while (exp_q.size() > 0) @(posedge wr_clk);
      repeat (4) @(posedge rd_clk);
      reader_on = 1'b0;
      $display("Test %s: %0d errors", name, error_count - errors_before);
   endtask

   task automatic run_flags();
      logic [DWIDTH-1:0] d;
      int                errors_before;
      int                written;
      errors_before = error_count;
      apply_reset(FIFO_1X, 1'b0);
      r_empty = count_t'(1);
      r_pempty = count_t'(4);
      r_pfull = count_t'(9);
      r_full = count_t'(12);
      written = 0;
      foreach (flag_points[k]) begin
         while (written < flag_points[k]) begin
            take_bits(DWIDTH, d);
            drive_beat(1'b1, d);
            model_beat(d);
            written++;
         end
         drive_beat(1'b0, '0);
         repeat (10) @(posedge wr_clk);  // Let both crossings settle
         repeat (10) @(posedge rd_clk);
         #1;
         check_value("wr_flags", EWIDTH'(flag_rules(written)),
                     EWIDTH'({wr_empty, wr_pempty, wr_full, wr_pfull}));
         check_value("rd_flags", EWIDTH'(flag_rules(written)),
                     EWIDTH'({rd_empty, rd_pempty, rd_full, rd_pfull}));
      end
      r_empty = count_t'(0);  // Reader needs rd_empty low on the last entry
      reader_on = 1'b1;
      while (exp_q.size() > 0) @(posedge rd_clk);
      repeat (10) @(posedge wr_clk);
      repeat (10) @(posedge rd_clk);
      #1;
      check_value("wr_empty", EWIDTH'(1'b1), EWIDTH'(wr_empty));
      check_value("rd_empty", EWIDTH'(1'b1), EWIDTH'(rd_empty));
      reader_on = 1'b0;
      $display("Test flags: %0d errors", error_count - errors_before);
   endtask

   // **************************************************
   // Reader with watchdog, timeout, main sequence
   // **************************************************
   initial begin
      rd_en = 1'b0;
      forever begin
         @(posedge rd_clk);
         #1;
         if (rd_en) begin
            rd_en = 1'b0;  // Idle cycle, rd_empty lags a read by one stage
         end else if (reader_on && !rd_empty) begin
            if (exp_q.size() == 0) begin
               error_count++;
               $display("Error at %0t: rd_empty is low but no entry was written", $time);
            end else begin
               check_value("rd_data", exp_q[0] & mask_q[0], rd_data & mask_q[0]);
               void'(exp_q.pop_front());
               void'(mask_q.pop_front());
            end
            rd_en = 1'b1;
         end
         if (reader_on && rd_empty && exp_q.size() > 0) empty_wait++;
         else empty_wait = 0;
         if (empty_wait > 20) begin
            error_count++;
            $display("Error at %0t: rd_empty stayed high for 20 rd_clk cycles %s",
                     $time, "with an entry written");
            empty_wait = 0;
         end
      end
   end

   initial begin
      while (cycle_count < MAX_CYCLES) begin
         @(posedge wr_clk);
         cycle_count++;
      end
      $display("Timeout: run did not finish within %0d wr_clk cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      wr_rst_n    = 1'b0;
      rd_rst_n    = 1'b0;
      wr_en       = 1'b0;
      wr_data     = '0;
      r_empty     = count_t'(0);
      r_pempty    = count_t'(3);
      r_pfull     = count_t'(8);
      r_full      = count_t'(15);
      r_fifo_mode = FIFO_4X;
      r_wa_en     = 1'b1;
      m_gen2_mode = 1'b1;
      r_mkbit     = 5'b00001;  // Marker taken from bit 39
      apply_reset(FIFO_4X, 1'b1);  // 4x keeps wa_lock low without markers
      check_value("wr_flags", EWIDTH'(4'b1100),
                  EWIDTH'({wr_empty, wr_pempty, wr_full, wr_pfull}));
      check_value("rd_flags", EWIDTH'(4'b1100),
                  EWIDTH'({rd_empty, rd_pempty, rd_full, rd_pfull}));
      check_value("wa_lock", '0, EWIDTH'(wa_lock));
      $display("Test reset: %0d errors", error_count);
      run_traffic("full_rate", FIFO_1X, 1'b1, N_1X, 1'b0);
      run_traffic("quarter_rate_lock", FIFO_4X, 1'b1, N_4X, 1'b1);
      run_traffic("half_rate_gen2", FIFO_2X, 1'b1, N_2X, 1'b0);
      run_traffic("half_rate_gen1", FIFO_2X, 1'b0, N_2X, 1'b0);
      run_flags();
      $display("Summary: 6 tests, %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- rxdp_async_fifo.f
src/rxdp_mode_pkg.sv
src/rxdp_fifo_pkg.sv
src/rxdp_fifo_ram.sv
src/rxdp_fifo_ptr.sv
src/rxdp_fifo_flags.sv
src/rxdp_word_packer.sv
src/rxdp_marker_lock.sv
src/rxdp_async_fifo.sv
tb/rxdp_async_fifo_sva.sv
tb/rxdp_async_fifo_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the RX adapter FIFO testbench with Verilator, run it, and scan the log.
# A crashed or aborted run counts as a failure.

verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
   --top-module rxdp_async_fifo_tb -f rxdp_async_fifo.f -o rxdp_sim \
   > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/rxdp_sim > sim.log 2>&1 || echo "Result: FAILED" >> sim.log

cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
